/* bench/px_chk.sv */
// Strobe and bus handshake assertions
`timescale 1ns/1ps

module px_chk import px_pkg::*; (
	input logic got,
	input logic clo_,
	input logic strob1,
	input logic strob2,
	input logic state_load,
	input logic alarm,
	input px_bus_req_t bus_req,
	input px_bus_ans_t bus_ans
);

	logic answer_seen; // Granted answer of any kind

	assign answer_seen = bus_ans.zw & (bus_ans.ok | bus_ans.en | bus_ans.pe);

	// Strobe phases never overlap
	strobe_apart: assert property (@(posedge got) disable iff (!clo_)
		!(strob1 && strob2))
		else $error("strob1 and strob2 high together");

	load_single: assert property (@(posedge got) disable iff (!clo_)
		state_load |=> !state_load)
		else $error("state_load longer than one clock");

	// Request released by an answer, or by the timeout that raises alarm
	zg_release: assert property (@(posedge got) disable iff (!clo_)
		$fell(bus_req.zg) |-> ($past(answer_seen) || $rose(alarm)))
		else $error("zg dropped without answer or timeout");

endmodule

bind px_top px_chk chk_i (
	.got(got),
	.clo_(clo_),
	.strob1(strob1),
	.strob2(strob2),
	.state_load(state_load),
	.alarm(alarm),
	.bus_req(bus_req),
	.bus_ans(bus_ans)
);

/* bench/px_tb.sv */
// PX state control testbench
`timescale 1ns/1ps

module px_tb import px_pkg::*; ;

	localparam int ALARM_TICKS = 20; // Short timeout for the bench
	localparam int NTESTS = 24;
	localparam int K_OK = 0; // Answer kinds
	localparam int K_EN = 1;
	localparam int K_PE = 2;
	localparam int K_NONE = 3; // No answer at all
	localparam int STEP_IDLE = 10; // Held clocks before the step key, longer than strobe 2

	typedef struct packed {
		px_state_t next; // State after the load
		logic has_grp;
		logic [2:0] grp;
		logic [3:0] ticks; // Strobe 1 clocks
		logic s2;
		logic bus;
		logic rd;
		logic wr;
	} exp_t;

	logic got;
	logic clo_;
	logic mode;
	logic step_;
	px_state_t ent;
	px_bus_ans_t bus_ans;
	px_state_t state;
	logic strob1;
	logic strob2;
	logic state_load;
	logic alarm;
	logic hlt_n;
	px_bus_req_t bus_req;

	logic [31:0] seed;
	int errors;
	int n_checks;
	int st_idx[NTESTS+1]; // 22 means no state
	int kind[NTESTS+1];
	int delay[NTESTS+1]; // Answer delay in clocks
	logic [4:0] rsvd_junk[NTESTS+1]; // Garbage on the reserved enter lines
	logic step_on[NTESTS+1];
	int cur_kind; // Responder setting for the running cycle
	int cur_delay;
	int wait_n;
	logic alarm_exp; // Sticky after the timeout test

	px_top #(
		.ALARM_TICKS(ALARM_TICKS),
		.STOP_ON_NOMEM(1'b1)
	) dut_i (
		.got(got),
		.clo_(clo_),
		.ent(ent),
		.mode(mode),
		.step_(step_),
		.bus_ans(bus_ans),
		.state(state),
		.strob1(strob1),
		.strob2(strob2),
		.state_load(state_load),
		.bus_req(bus_req),
		.alarm(alarm),
		.hlt_n(hlt_n)
	);

	function automatic int lcg_pick(input int n);
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'(seed[30:16]) % n; // Upper bits of the LCG state
	endfunction

	// k1 is the top bit and index 21 is i5
	function automatic px_state_t state_of(input int idx);
		px_state_t s;
		s = '0;
		if (idx < 22) s = px_state_t'(27'(1) << (26 - idx));
		return s;
	endfunction

	// Enter lines of one test with junk on the reserved bits
	function automatic px_state_t enter_of(input int k);
		px_state_t s;
		s = state_of(st_idx[k]);
		s.rsvd = rsvd_junk[k];
		return s;
	endfunction

	// Expected cycle from the enter lines
	function automatic exp_t predict(input px_state_t e);
		exp_t r;
		r = '0;
		r.next = e;
		r.next.rsvd = '0; // Reserved bits never load
		r.has_grp = 1'b1;
		if (e.we | e.w_s | e.p4) r.grp = 3'd0;
		else if (e.p1 | e.k1 | e.k2 | e.i1 | e.i3) r.grp = 3'd1;
		else if (e.p5 | e.wr | e.ww | e.wm | e.i2 | e.i4 | e.i5) r.grp = 3'd2;
		else if (e.wz | e.p3 | e.wa | e.p0) r.grp = 3'd3;
		else if (e.p2 | e.wp | e.wx) r.grp = 3'd4;
		else r.has_grp = 1'b0;
		r.ticks = !r.has_grp ? 4'd0 : (r.grp == 3'd1) ? 4'd6 : 4'd5;
		r.s2 = r.has_grp & (r.grp <= 3'd1); // Groups 0 and 1
		r.bus = r.has_grp & (r.grp == 3'd1 || r.grp == 3'd2);
		r.wr = r.bus & (e.ww | e.wm | e.i5);
		r.rd = r.bus & ~r.wr;
		return r;
	endfunction

	task automatic compare_value(input string name, input int got_v, input int exp_v);
		n_checks++;
		if (got_v !== exp_v) begin
			errors++;
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, name, got_v, exp_v);
		end
	endtask

	initial begin
		got = 1'b0;
		forever #50 got = ~got; // 100 ns period
	end

	// Grants at once and answers after the chosen delay
	initial begin
		bus_ans = '0;
		wait_n = 0;
		forever begin
			@(posedge got);
			#10;
			if (bus_req.zg) begin
				if (wait_n == cur_delay && cur_kind != K_NONE) begin
					bus_ans = '{zw: 1'b1, ok: cur_kind == K_OK, en: cur_kind == K_EN,
						pe: cur_kind == K_PE};
				end
				wait_n++;
			end else begin
				bus_ans = '0;
				wait_n = 0;
			end
		end
	end

	initial begin
		#((NTESTS * (ALARM_TICKS + 40) + 10) * 100);
		$display("Timeout: the run did not finish within the expected time");
		$display("Errors found");
		$finish;
	end

	initial begin
		exp_t ex;
		int c;
		int s1_cnt;
		int s2_cnt;
		int first_s1;
		int zg_cnt;
		int rd_cnt;
		int wr_cnt;
		int zg_exp;
		int idle;
		int err_before;
		logic fin;
		logic pressed;
		seed = 63;
		errors = 0;
		n_checks = 0;
		alarm_exp = 1'b0;
		for (int k = 0; k <= NTESTS; k++) begin
			st_idx[k] = lcg_pick(22);
			kind[k] = lcg_pick(3);
			delay[k] = lcg_pick(6);
			rsvd_junk[k] = 5'(lcg_pick(32));
			step_on[k] = 1'b0;
		end
		st_idx[4] = 12; // wr never answered
		kind[4] = K_NONE;
		st_idx[8] = 14; // ww answered with no memory
		kind[8] = K_EN;
		st_idx[12] = 11; // we under single step
		step_on[12] = 1'b1;
		st_idx[16] = 22; // Empty state without a group
		cur_kind = K_OK;
		cur_delay = 0;
		clo_ = 1'b0;
		mode = 1'b0;
		step_ = 1'b1;
		ent = enter_of(0);
		repeat (4) @(posedge got);
		#10;
		compare_value("state in reset", state, state_of(2));
		compare_value("outputs in reset", {strob1, strob2, bus_req.zg, alarm, state_load, hlt_n},
			6'b000001);
		clo_ = 1'b1;
		do @(negedge got); while (!state_load); // P0 cycle ends
		for (int k = 0; k < NTESTS; k++) begin
			err_before = errors;
			cur_kind = kind[k];
			cur_delay = delay[k];
			ex = predict(enter_of(k));
			@(posedge got);
			#10;
			ent = enter_of(k + 1); // Loaded at the end of this cycle
			mode = step_on[k];
			step_ = 1'b1;
			c = 0;
			s1_cnt = 0;
			s2_cnt = 0;
			first_s1 = -1;
			zg_cnt = 0;
			rd_cnt = 0;
			wr_cnt = 0;
			idle = 0;
			pressed = 1'b0;
			fin = 1'b0;
			while (!fin) begin
				@(negedge got);
				if (c == 0) begin
					compare_value("state", state, ex.next);
					compare_value("hlt_n after load", hlt_n, 1);
					compare_value("zg after load", bus_req.zg, ex.bus);
				end
				if (strob1) begin
					if (first_s1 < 0) first_s1 = c;
					s1_cnt++;
				end
				if (strob2) s2_cnt++;
				if (bus_req.zg) begin
					zg_cnt++;
					rd_cnt += int'(bus_req.rd);
					wr_cnt += int'(bus_req.wr);
				end
				if (state_load) begin
					fin = 1'b1;
				end else begin
					if (step_on[k] && s1_cnt > 0 && !strob1) idle++; // Held in step
					@(posedge got);
					#10;
					step_ = 1'b1;
					if (idle == STEP_IDLE && !pressed) begin
						compare_value("strob2 before step", s2_cnt, 0);
						step_ = 1'b0; // One step sample
						pressed = 1'b1;
					end
					c++;
				end
			end
			if (step_on[k] && !pressed) begin
				errors++;
				$display("Cycle ended at %0d ns in step mode without a step pulse", $time);
			end
			zg_exp = !ex.bus ? 0 : (cur_kind == K_NONE) ? ALARM_TICKS : cur_delay + 1;
			if (ex.bus && cur_kind == K_NONE) alarm_exp = 1'b1;
			compare_value("strob1 clocks", s1_cnt, ex.ticks);
			compare_value("strob2 clocks", s2_cnt, ex.s2 ? 6 : 0);
			compare_value("zg clocks", zg_cnt, zg_exp);
			compare_value("rd clocks", rd_cnt, ex.rd ? zg_exp : 0);
			compare_value("wr clocks", wr_cnt, ex.wr ? zg_exp : 0);
			if (ex.has_grp) begin
				compare_value("strob1 start", first_s1, ex.bus ? zg_exp + 2 : 1);
			end else begin
				compare_value("cycle length", c + 1, 2);
			end
			compare_value("alarm", alarm, alarm_exp);
			compare_value("hlt_n", hlt_n, !(ex.bus && cur_kind == K_EN));
			$display("Test %0d state index %0d: %s", k, st_idx[k],
				(errors == err_before) ? "ok" : "failed");
		end
		$display("Tests %0d, checks %0d, errors %0d", NTESTS, n_checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* logic/px_bus_ctrl.sv */
// System bus request control
`timescale 1ns/1ps

module px_bus_ctrl import px_pkg::*; #(
	parameter int ALARM_TICKS = 250, // Answer timeout
	parameter bit STOP_ON_NOMEM = 1'b1 // Halt on missing memory
) (
	input logic got,
	input logic clo_,
	input px_state_t state,
	input logic state_load,
	input px_bus_ans_t bus_ans,
	output px_bus_req_t bus_req,
	output logic bus_ready, // Answer or timeout seen
	output logic alarm, // Sticky timeout
	output logic hlt_n
);

	localparam int TW = $clog2(ALARM_TICKS + 1); // Timeout counter width

	logic load_d; // First clock of a cycle
	logic req_q; // Request flip-flop
	logic req_on; // Request raise
	logic zg;
	logic bus_hit; // Memory state active
	logic write_hit; // Write state active
	logic answer; // OK, EN or PE under grant
	logic timeout;
	logic nomem; // EN answer that halts
	logic [TW-1:0] wait_cnt; // Clocks of request so far

	assign bus_hit = |(state & BUS_MASK);
	assign write_hit = |(state & WRITE_MASK);

	// Raised on first clock, held by the flip-flop after
	assign req_on = load_d & bus_hit;
	assign zg = req_q | req_on;

	assign answer = zg & bus_ans.zw & (bus_ans.ok | bus_ans.en | bus_ans.pe);
	assign timeout = zg & ~answer & (wait_cnt == TW'(ALARM_TICKS - 1));
	assign nomem = answer & bus_ans.en & STOP_ON_NOMEM;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			load_d <= 1'b0;
			req_q <= 1'b0;
			bus_ready <= 1'b0;
			alarm <= 1'b0;
			hlt_n <= 1'b1;
			wait_cnt <= '0;
		end else begin
			load_d <= state_load;
			req_q <= zg & ~(answer | timeout); // Drop after answer
			bus_ready <= answer | timeout; // One clock
			if (timeout) begin
				alarm <= 1'b1; // Cleared only by reset
			end
			if (zg & ~(answer | timeout)) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
			end
			if (state_load) begin
				hlt_n <= 1'b1; // Released by next load
			end else if (nomem) begin
				hlt_n <= 1'b0;
			end
		end
	end

	// Direction only while requesting
	assign bus_req = '{zg: zg, rd: zg & ~write_hit, wr: zg & write_hit};

endmodule

/* logic/px_cycle_decode.sv */
// Strobe group decode
`timescale 1ns/1ps

module px_cycle_decode import px_pkg::*; (
	input logic got,
	input logic clo_,
	input px_state_t state,
	input logic state_load,
	input logic first_load,
	input logic bus_ready, // Bus answer seen
	output logic [NGROUPS-1:0] grp_start,
	output logic need_strob2,
	output logic [NGROUPS-1:0] grp_used // Groups active this cycle
);

	logic load_d; // First clock of a cycle
	logic ready_d; // Clock after bus_ready
	logic [NGROUPS-1:0] grp_hit; // Live group decode
	logic [NGROUPS-1:0] used_q; // Groups latched for the cycle

	// State against each group mask
	always_comb begin
		for (int g = 0; g < NGROUPS; g++) begin
			grp_hit[g] = |(state & GROUP_MASK[g]);
		end
	end

	// Live decode on the first clock, latched after
	assign grp_used = load_d ? grp_hit : used_q;

	// Non-bus groups fire at once, bus groups wait for the answer
	assign grp_start = (grp_used & ~BUS_GROUPS & {NGROUPS{load_d}}) |
		(grp_used & BUS_GROUPS & {NGROUPS{ready_d}});

	assign need_strob2 = |(grp_used & STROB2_GROUPS); // Groups 0 and 1

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			load_d <= 1'b0;
			ready_d <= 1'b0;
			used_q <= '0;
		end else begin
			load_d <= state_load | first_load; // Cycle begins next clock
			ready_d <= bus_ready;
			if (load_d) begin
				used_q <= grp_hit; // Hold until next load
			end
		end
	end

endmodule

/* logic/px_cycle_end.sv */
// Cycle end sequencer
`timescale 1ns/1ps

module px_cycle_end import px_pkg::*; (
	input logic got,
	input logic clo_,
	input logic [NGROUPS-1:0] pulse, // Timer outputs
	input logic [NGROUPS-1:0] done,
	input logic [NGROUPS-1:0] grp_used,
	input logic need_strob2,
	input logic mode, // Single step
	input logic step_, // Step key, low active
	output logic strob1,
	output logic strob2,
	output logic state_load
);

	localparam int SW = $clog2(STROB2_TICKS); // Strobe 2 counter width

	typedef enum logic [2:0] {
		PH_START, // After clear, no load
		PH_WAIT, // Groups running
		PH_STEP, // Step hold
		PH_STROB2,
		PH_LOAD // Load pulse
	} ph_t;

	ph_t ph, ph_nxt;
	logic [NGROUPS-1:0] seen; // Done bits so far
	logic [SW-1:0] s2_cnt; // Strobe 2 clocks left minus one
	logic all_done;
	ph_t after_hold; // Phase once step is released

	assign all_done = &(seen | done | ~grp_used); // Unused groups count as done
	assign after_hold = need_strob2 ? PH_STROB2 : PH_LOAD;

	always_comb begin
		ph_nxt = ph;
		case (ph)
			PH_START, PH_LOAD: ph_nxt = PH_WAIT;
			PH_WAIT: if (all_done) ph_nxt = mode ? PH_STEP : after_hold;
			PH_STEP: if (!step_) ph_nxt = after_hold; // Low sample releases
			PH_STROB2: if (s2_cnt == '0) ph_nxt = PH_LOAD;
			default: ph_nxt = PH_WAIT;
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ph <= PH_START;
			seen <= '0;
			s2_cnt <= '0;
		end else begin
			ph <= ph_nxt;
			if (ph == PH_LOAD || ph == PH_START) begin
				seen <= '0; // New cycle
			end else begin
				seen <= seen | done;
			end
			if (ph_nxt == PH_STROB2 && ph != PH_STROB2) begin
				s2_cnt <= SW'(STROB2_TICKS - 1); // Arm strobe 2
			end else if (ph == PH_STROB2) begin
				s2_cnt <= s2_cnt - 1'b1;
			end
		end
	end

	assign strob1 = |pulse; // Any group strobe
	assign strob2 = (ph == PH_STROB2);
	assign state_load = (ph == PH_LOAD); // One clock

endmodule

/* logic/px_pkg.sv */
// PX state control definitions
package px_pkg;

	localparam int PX_STATE_W = 27; // 22 states plus reserved
	localparam int NGROUPS = 5; // Strobe groups

	// One-hot machine states, k1 in the top bit
	typedef struct packed {
		logic k1; // Fetch, first word
		logic k2; // Fetch, second word
		logic p0; // Start state
		logic p1;
		logic p2;
		logic p3;
		logic p4;
		logic p5;
		logic wp;
		logic wa;
		logic wz;
		logic we;
		logic wr; // Memory read
		logic w_s;
		logic ww; // Memory write
		logic wm; // Memory modify
		logic wx;
		logic i1; // Interrupt phases
		logic i2;
		logic i3;
		logic i4;
		logic i5;
		logic [4:0] rsvd; // Always zero
	} px_state_t;

	typedef struct packed {
		logic zg; // Bus request
		logic rd; // Read cycle
		logic wr; // Write cycle
	} px_bus_req_t;

	typedef struct packed {
		logic zw; // Grant
		logic ok; // Answer OK
		logic en; // No memory
		logic pe; // Parity error
	} px_bus_ans_t;

	localparam px_state_t P0_STATE = '{p0: 1'b1, default: '0}; // After clear

	// Per-group state sets
	localparam px_state_t G0_MASK = '{we: 1'b1, w_s: 1'b1, p4: 1'b1, default: '0};
	localparam px_state_t G1_MASK = '{p1: 1'b1, k1: 1'b1, k2: 1'b1, i1: 1'b1, i3: 1'b1,
		default: '0};
	localparam px_state_t G2_MASK = '{p5: 1'b1, wr: 1'b1, ww: 1'b1, wm: 1'b1, i2: 1'b1,
		i4: 1'b1, i5: 1'b1, default: '0};
	localparam px_state_t G3_MASK = '{wz: 1'b1, p3: 1'b1, wa: 1'b1, p0: 1'b1, default: '0};
	localparam px_state_t G4_MASK = '{p2: 1'b1, wp: 1'b1, wx: 1'b1, default: '0};

	localparam logic [NGROUPS-1:0][PX_STATE_W-1:0] GROUP_MASK =
		{G4_MASK, G3_MASK, G2_MASK, G1_MASK, G0_MASK}; // Index 0 is group 0

	localparam logic [NGROUPS-1:0][3:0] GROUP_TICKS =
		{4'd5, 4'd5, 4'd5, 4'd6, 4'd5}; // Strobe 1 lengths, group 0 rightmost
	localparam int STROB2_TICKS = 6; // Strobe 2 length

	localparam logic [NGROUPS-1:0] BUS_GROUPS = 5'b00110; // Groups 1 and 2
	localparam logic [NGROUPS-1:0] STROB2_GROUPS = 5'b00011; // Groups 0 and 1

	localparam px_state_t BUS_MASK = px_state_t'(G1_MASK | G2_MASK); // Memory states
	localparam px_state_t WRITE_MASK = '{ww: 1'b1, wm: 1'b1, i5: 1'b1, default: '0};

endpackage

/* logic/px_state_reg.sv */
// Machine state register
`timescale 1ns/1ps

module px_state_reg import px_pkg::*; (
	input logic got,
	input logic clo_,
	input px_state_t ent, // Enter lines
	input logic state_load, // End of cycle
	output px_state_t state,
	output logic first_load // Starts the cycle after clear
);

	logic started; // Set by first clock after clear
	px_state_t ent_clean; // Enter vector, reserved bits dropped

	always_comb begin
		ent_clean = ent;
		ent_clean.rsvd = '0; // Never carry reserved bits
	end

	// Clear presets P0 alone
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= P0_STATE;
		end else if (state_load) begin
			state <= ent_clean; // New states at cycle end
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			started <= 1'b0;
		end else begin
			started <= 1'b1; // Stays set until next clear
		end
	end

	// High until the first clock, stands in for a load
	assign first_load = ~started;

endmodule

/* logic/px_strob_timer.sv */
// Strobe 1 pulse timer
`timescale 1ns/1ps

module px_strob_timer #(
	parameter int TICKS = 5 // Pulse length in clocks
) (
	input logic got,
	input logic clo_,
	input logic start,
	output logic pulse,
	output logic done
);

	localparam int CW = $clog2(TICKS + 1); // Counter width

	logic [CW-1:0] cnt; // Clocks of pulse left

	// Down counter in place of the one-shot
	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= (cnt == CW'(1)); // Last pulse clock
			if (start) begin
				cnt <= CW'(TICKS); // Retrigger
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	assign pulse = (cnt != '0); // High while counting

endmodule

/* logic/px_top.sv */
// PX state control unit
`timescale 1ns/1ps

module px_top import px_pkg::*; #(
	parameter int ALARM_TICKS = 250,
	parameter bit STOP_ON_NOMEM = 1'b1
) (
	input logic got, // System clock
	input logic clo_, // General clear
	input px_state_t ent, // Enter lines from microcode
	input logic mode,
	input logic step_,
	input px_bus_ans_t bus_ans,
	output px_state_t state,
	output logic strob1,
	output logic strob2,
	output logic state_load,
	output px_bus_req_t bus_req,
	output logic alarm,
	output logic hlt_n
);

	logic first_load; // Cycle start after clear
	logic bus_ready;
	logic need_strob2;
	logic [NGROUPS-1:0] grp_start; // Per-group triggers
	logic [NGROUPS-1:0] grp_used;
	logic [NGROUPS-1:0] pulse; // Per-group strobe 1
	logic [NGROUPS-1:0] done;

	px_state_reg u_state_reg (
		.got(got),
		.clo_(clo_),
		.ent(ent),
		.state_load(state_load),
		.state(state),
		.first_load(first_load)
	);

	px_cycle_decode u_cycle_decode (
		.got(got),
		.clo_(clo_),
		.state(state),
		.state_load(state_load),
		.first_load(first_load),
		.bus_ready(bus_ready),
		.grp_start(grp_start),
		.need_strob2(need_strob2),
		.grp_used(grp_used)
	);

	// One timer per strobe group
	for (genvar g = 0; g < NGROUPS; g++) begin : g_timer
		px_strob_timer #(
			.TICKS(int'(GROUP_TICKS[g]))
		) u_timer (
			.got(got),
			.clo_(clo_),
			.start(grp_start[g]),
			.pulse(pulse[g]),
			.done(done[g])
		);
	end

	px_cycle_end u_cycle_end (
		.got(got),
		.clo_(clo_),
		.pulse(pulse),
		.done(done),
		.grp_used(grp_used),
		.need_strob2(need_strob2),
		.mode(mode),
		.step_(step_),
		.strob1(strob1),
		.strob2(strob2),
		.state_load(state_load)
	);

	px_bus_ctrl #(
		.ALARM_TICKS(ALARM_TICKS),
		.STOP_ON_NOMEM(STOP_ON_NOMEM)
	) u_bus_ctrl (
		.got(got),
		.clo_(clo_),
		.state(state),
		.state_load(state_load),
		.bus_ans(bus_ans),
		.bus_req(bus_req),
		.bus_ready(bus_ready),
		.alarm(alarm),
		.hlt_n(hlt_n)
	);

endmodule

/* px_top.f */
logic/px_pkg.sv
logic/px_state_reg.sv
logic/px_cycle_decode.sv
logic/px_strob_timer.sv
logic/px_cycle_end.sv
logic/px_bus_ctrl.sv
logic/px_top.sv
bench/px_chk.sv
bench/px_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the px_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module px_tb \
	-f px_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/Vpx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0
